// File: ext_mem_pkg.sv
package ext_mem_pkg;

   // Bus widths
   localparam int addr_w = 14;  // Word address
   localparam int data_w = 32;
   localparam int strb_w = 4;   // Nonzero strobe marks a write

   // Level-one geometry, direct mapped, one word per line
   localparam int l1_index_w = 5;
   localparam int l1_tag_w   = 9;
   localparam int l1_lines   = 1 << l1_index_w;

   // Level-two geometry
   localparam int l2_index_w = 7;
   localparam int l2_tag_w   = 7;
   localparam int l2_lines   = 1 << l2_index_w;

   // FSM encodings
   localparam logic [1:0] l1_st_idle  = 2'd0;
   localparam logic [1:0] l1_st_read  = 2'd1;  // Refill after a read miss
   localparam logic [1:0] l1_st_write = 2'd2;  // Write passing down the bus

   localparam logic [1:0] l2_st_idle  = 2'd0;
   localparam logic [1:0] l2_st_fill  = 2'd1;
   localparam logic [1:0] l2_st_write = 2'd2;

   // Word address seen flat or as tag and index
   typedef union packed {
      logic [addr_w-1:0] word;
      struct packed {
         logic [l1_tag_w-1:0]   tag;
         logic [l1_index_w-1:0] index;
      } split;
   } l1_addr_t;

   typedef union packed {
      logic [addr_w-1:0] word;
      struct packed {
         logic [l2_tag_w-1:0]   tag;
         logic [l2_index_w-1:0] index;
      } split;
   } l2_addr_t;

   // Replace only the strobed bytes of a stored word
   function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_word,
                                                     input logic [data_w-1:0] new_word,
                                                     input logic [strb_w-1:0] strb);
      logic [data_w-1:0] result;
      result = old_word;
      for (int b = 0; b < strb_w; b++) begin
         if (strb[b])
            result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

endpackage

// File: l1_cache.sv
module l1_cache (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              invalidate,
   // Front end
   input  logic                              valid,
   input  logic [ext_mem_pkg::addr_w-1:0]    addr,
   input  logic [ext_mem_pkg::data_w-1:0]    wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]    wstrb,
   output logic [ext_mem_pkg::data_w-1:0]    rdata,
   output logic                              ready,
   // Back end
   output logic                              mem_valid,
   output logic [ext_mem_pkg::addr_w-1:0]    mem_addr,
   output logic [ext_mem_pkg::data_w-1:0]    mem_wdata,
   output logic [ext_mem_pkg::strb_w-1:0]    mem_wstrb,
   input  logic [ext_mem_pkg::data_w-1:0]    mem_rdata,
   input  logic                              mem_ready
);

   ext_mem_pkg::l1_addr_t req_addr;

   logic [ext_mem_pkg::l1_tag_w-1:0] tag_mem  [ext_mem_pkg::l1_lines];
   logic [ext_mem_pkg::data_w-1:0]   data_mem [ext_mem_pkg::l1_lines];
   logic [ext_mem_pkg::l1_lines-1:0] line_valid;

   logic [1:0] state;
   logic       accept;
   logic       is_write;
   logic       hit;

   assign req_addr = addr;
   assign is_write = |wstrb;

   // Skip the ready cycle, the requester still holds valid there
   assign accept = (state == ext_mem_pkg::l1_st_idle) && valid && !ready;

   assign hit = line_valid[req_addr.split.index] &&
                (tag_mem[req_addr.split.index] == req_addr.split.tag);

   // Back end follows the held front-end request
   assign mem_valid = (state != ext_mem_pkg::l1_st_idle);
   assign mem_addr  = addr;
   assign mem_wdata = wdata;
   assign mem_wstrb = (state == ext_mem_pkg::l1_st_write) ? wstrb : '0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= ext_mem_pkg::l1_st_idle;
         ready      <= 1'b0;
         line_valid <= '0;
      end else begin
         ready <= 1'b0;
         case (state)
            ext_mem_pkg::l1_st_idle: begin
               if (accept) begin
                  if (is_write)
                     state <= ext_mem_pkg::l1_st_write;
                  else if (hit)
                     ready <= 1'b1;  // One-cycle hit
                  else
                     state <= ext_mem_pkg::l1_st_read;
               end
            end
            ext_mem_pkg::l1_st_read: begin
               if (mem_ready) begin
                  ready <= 1'b1;
                  state <= ext_mem_pkg::l1_st_idle;
                  line_valid[req_addr.split.index] <= 1'b1;
               end
            end
            ext_mem_pkg::l1_st_write: begin
               if (mem_ready) begin
                  ready <= 1'b1;
                  state <= ext_mem_pkg::l1_st_idle;
               end
            end
            default: state <= ext_mem_pkg::l1_st_idle;
         endcase
         // Flush wins over a refill landing on the same edge
         if (invalidate)
            line_valid <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept && !is_write && hit)
         rdata <= data_mem[req_addr.split.index];
      if (state == ext_mem_pkg::l1_st_read && mem_ready) begin
         rdata                             <= mem_rdata;
         data_mem[req_addr.split.index]    <= mem_rdata;
         tag_mem[req_addr.split.index]     <= req_addr.split.tag;
      end
      // No allocate on a write miss
      if (state == ext_mem_pkg::l1_st_write && mem_ready && hit)
         data_mem[req_addr.split.index] <=
            ext_mem_pkg::merge_bytes(data_mem[req_addr.split.index], wdata, wstrb);
   end

   a_addr_held: assert property (@(posedge clk) disable iff (rst)
      valid && !ready |=> valid && $stable(addr));

endmodule

// File: bus_merge.sv
module bus_merge (
   input  logic                                  clk,
   input  logic                                  rst,
   // Master 0 is the instruction cache and master 1 the data cache
   input  logic [1:0]                            m_valid,
   input  logic [1:0][ext_mem_pkg::addr_w-1:0]   m_addr,
   input  logic [1:0][ext_mem_pkg::data_w-1:0]   m_wdata,
   input  logic [1:0][ext_mem_pkg::strb_w-1:0]   m_wstrb,
   output logic [ext_mem_pkg::data_w-1:0]        m_rdata,
   output logic [1:0]                            m_ready,
   // Slave side
   output logic                                  s_valid,
   output logic [ext_mem_pkg::addr_w-1:0]        s_addr,
   output logic [ext_mem_pkg::data_w-1:0]        s_wdata,
   output logic [ext_mem_pkg::strb_w-1:0]        s_wstrb,
   input  logic [ext_mem_pkg::data_w-1:0]        s_rdata,
   input  logic                                  s_ready
);

   logic locked;   // Grant held until s_ready
   logic grant_q;
   logic sel;

   // Fixed priority to the data cache when free
   assign sel = locked ? grant_q : m_valid[1];

   assign s_valid = m_valid[sel];
   assign s_addr  = m_addr[sel];
   assign s_wdata = m_wdata[sel];
   assign s_wstrb = m_wstrb[sel];

   assign m_rdata    = s_rdata;  // Data goes to both masters and ready only to the granted one
   assign m_ready[0] = s_ready & ~sel;
   assign m_ready[1] = s_ready & sel;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         locked  <= 1'b0;
         grant_q <= 1'b0;
      end else if (s_ready) begin
         locked <= 1'b0;
      end else if (s_valid && !locked) begin
         locked  <= 1'b1;
         grant_q <= sel;
      end
   end

   // Ready only reaches a master that still holds its request
   a_ready_to_requester: assert property (@(posedge clk) disable iff (rst)
      (m_ready & ~m_valid) == '0);

   // Slave must never see the request switch masters midway
   a_grant_held: assert property (@(posedge clk) disable iff (rst)
      s_valid && !s_ready |=> s_valid && (sel == $past(sel)));

endmodule

// File: l2_cache.sv
module l2_cache (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              invalidate,
   // Front end from the merge unit
   input  logic                              valid,
   input  logic [ext_mem_pkg::addr_w-1:0]    addr,
   input  logic [ext_mem_pkg::data_w-1:0]    wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]    wstrb,
   output logic [ext_mem_pkg::data_w-1:0]    rdata,
   output logic                              ready,
   // Main memory
   output logic                              mem_valid,
   output logic [ext_mem_pkg::addr_w-1:0]    mem_addr,
   output logic [ext_mem_pkg::data_w-1:0]    mem_wdata,
   output logic [ext_mem_pkg::strb_w-1:0]    mem_wstrb,
   input  logic [ext_mem_pkg::data_w-1:0]    mem_rdata,
   input  logic                              mem_ready
);

   ext_mem_pkg::l2_addr_t req_addr;

   logic [ext_mem_pkg::l2_tag_w-1:0] tag_mem  [ext_mem_pkg::l2_lines];
   logic [ext_mem_pkg::data_w-1:0]   data_mem [ext_mem_pkg::l2_lines];
   logic [ext_mem_pkg::l2_lines-1:0] line_valid;

   logic [1:0] state;
   logic       accept;
   logic       is_write;
   logic       hit;

   assign req_addr = addr;
   assign is_write = |wstrb;
   assign accept   = (state == ext_mem_pkg::l2_st_idle) && valid && !ready;

   assign hit = line_valid[req_addr.split.index] &&
                (tag_mem[req_addr.split.index] == req_addr.split.tag);

   // Memory request is registered here, unlike the level-one back end
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= ext_mem_pkg::l2_st_idle;
         ready      <= 1'b0;
         mem_valid  <= 1'b0;
         line_valid <= '0;
      end else begin
         ready <= 1'b0;
         if (state == ext_mem_pkg::l2_st_idle) begin
            if (accept && is_write) begin
               state     <= ext_mem_pkg::l2_st_write;
               mem_valid <= 1'b1;
            end else if (accept && !hit) begin
               state     <= ext_mem_pkg::l2_st_fill;
               mem_valid <= 1'b1;
            end else if (accept) begin
               ready <= 1'b1;
            end
         end else if (mem_ready) begin
            mem_valid <= 1'b0;
            ready     <= 1'b1;
            state     <= ext_mem_pkg::l2_st_idle;
            if (state == ext_mem_pkg::l2_st_fill)
               line_valid[req_addr.split.index] <= 1'b1;
         end
         if (invalidate)
            line_valid <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         mem_addr  <= addr;
         mem_wdata <= wdata;
         mem_wstrb <= wstrb;
         // Write hit updates the line right away, memory catches up later
         if (is_write && hit)
            data_mem[req_addr.split.index] <=
               ext_mem_pkg::merge_bytes(data_mem[req_addr.split.index], wdata, wstrb);
         else if (!is_write && hit)
            rdata <= data_mem[req_addr.split.index];
      end
      if (state == ext_mem_pkg::l2_st_fill && mem_ready) begin
         rdata                          <= mem_rdata;
         data_mem[req_addr.split.index] <= mem_rdata;
         tag_mem[req_addr.split.index]  <= req_addr.split.tag;
      end
   end

   // Guard register in the top level keeps flushes off busy cycles
   a_inv_idle: assert property (@(posedge clk) disable iff (rst)
      invalidate |-> !valid);

endmodule

// File: ext_mem.sv
module ext_mem (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              invalidate,
   // Instruction bus, reads only
   input  logic                              i_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]    i_addr,
   output logic [ext_mem_pkg::data_w-1:0]    i_rdata,
   output logic                              i_ready,
   // Data bus
   input  logic                              d_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]    d_addr,
   input  logic [ext_mem_pkg::data_w-1:0]    d_wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]    d_wstrb,
   output logic [ext_mem_pkg::data_w-1:0]    d_rdata,
   output logic                              d_ready,
   // Main memory
   output logic                              mem_valid,
   output logic [ext_mem_pkg::addr_w-1:0]    mem_addr,
   output logic [ext_mem_pkg::data_w-1:0]    mem_wdata,
   output logic [ext_mem_pkg::strb_w-1:0]    mem_wstrb,
   input  logic [ext_mem_pkg::data_w-1:0]    mem_rdata,
   input  logic                              mem_ready
);

   // Cache back ends, index 0 instruction and 1 data
   logic [1:0]                          be_valid;
   logic [1:0][ext_mem_pkg::addr_w-1:0] be_addr;
   logic [1:0][ext_mem_pkg::data_w-1:0] be_wdata;
   logic [1:0][ext_mem_pkg::strb_w-1:0] be_wstrb;
   logic [ext_mem_pkg::data_w-1:0]      be_rdata;
   logic [1:0]                          be_ready;

   // Level-two front end
   logic                           l2_valid;
   logic [ext_mem_pkg::addr_w-1:0] l2_addr;
   logic [ext_mem_pkg::data_w-1:0] l2_wdata;
   logic [ext_mem_pkg::strb_w-1:0] l2_wstrb;
   logic [ext_mem_pkg::data_w-1:0] l2_rdata;
   logic                           l2_ready;

   logic inv_pending;
   logic l2_inv;

   // Hold the flush until no request sits on the level-two front end
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         inv_pending <= 1'b0;
      else if (invalidate)
         inv_pending <= 1'b1;
      else if (!l2_valid)
         inv_pending <= 1'b0;
   end

   assign l2_inv = inv_pending & ~l2_valid;

   l1_cache u_icache (
      .clk        (clk),
      .rst        (rst),
      .invalidate (invalidate),
      .valid      (i_valid),
      .addr       (i_addr),
      .wdata      ('0),
      .wstrb      ('0),        // Never writes
      .rdata      (i_rdata),
      .ready      (i_ready),
      .mem_valid  (be_valid[0]),
      .mem_addr   (be_addr[0]),
      .mem_wdata  (be_wdata[0]),
      .mem_wstrb  (be_wstrb[0]),
      .mem_rdata  (be_rdata),
      .mem_ready  (be_ready[0])
   );

   l1_cache u_dcache (
      .clk        (clk),
      .rst        (rst),
      .invalidate (invalidate),
      .valid      (d_valid),
      .addr       (d_addr),
      .wdata      (d_wdata),
      .wstrb      (d_wstrb),
      .rdata      (d_rdata),
      .ready      (d_ready),
      .mem_valid  (be_valid[1]),
      .mem_addr   (be_addr[1]),
      .mem_wdata  (be_wdata[1]),
      .mem_wstrb  (be_wstrb[1]),
      .mem_rdata  (be_rdata),
      .mem_ready  (be_ready[1])
   );

   bus_merge u_merge (
      .clk     (clk),
      .rst     (rst),
      .m_valid (be_valid),
      .m_addr  (be_addr),
      .m_wdata (be_wdata),
      .m_wstrb (be_wstrb),
      .m_rdata (be_rdata),
      .m_ready (be_ready),
      .s_valid (l2_valid),
      .s_addr  (l2_addr),
      .s_wdata (l2_wdata),
      .s_wstrb (l2_wstrb),
      .s_rdata (l2_rdata),
      .s_ready (l2_ready)
   );

   l2_cache u_l2cache (
      .clk        (clk),
      .rst        (rst),
      .invalidate (l2_inv),
      .valid      (l2_valid),
      .addr       (l2_addr),
      .wdata      (l2_wdata),
      .wstrb      (l2_wstrb),
      .rdata      (l2_rdata),
      .ready      (l2_ready),
      .mem_valid  (mem_valid),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wstrb  (mem_wstrb),
      .mem_rdata  (mem_rdata),
      .mem_ready  (mem_ready)
   );

endmodule

// File: tb_mem_model.sv
module tb_mem_model (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              mem_valid,
   input  logic [ext_mem_pkg::addr_w-1:0]    mem_addr,
   input  logic [ext_mem_pkg::data_w-1:0]    mem_wdata,
   input  logic [ext_mem_pkg::strb_w-1:0]    mem_wstrb,
   output logic [ext_mem_pkg::data_w-1:0]    mem_rdata,
   output logic                              mem_ready
);

   logic [ext_mem_pkg::data_w-1:0] mem [1 << ext_mem_pkg::addr_w];
   logic [31:0] lfsr = 32'h6cb2;
   logic        busy;
   logic [1:0]  wait_cnt;  // Extra cycles before ready

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   task automatic backdoor_write(input logic [ext_mem_pkg::addr_w-1:0] a,
                                 input logic [ext_mem_pkg::data_w-1:0] d);
      mem[a] = d;
   endtask

   always @(posedge clk or posedge rst) begin
      if (rst) begin
         mem_ready <= 1'b0;
         mem_rdata <= '0;
         busy      <= 1'b0;
         wait_cnt  <= 2'd0;
      end else begin
         mem_ready <= 1'b0;
         if (mem_ready)
            busy <= 1'b0;  // Request drops on this edge
         else if (mem_valid && !busy) begin
            busy     <= 1'b1;
            wait_cnt <= 2'(take_bits(2));
         end else if (busy && wait_cnt != 2'd0)
            wait_cnt <= wait_cnt - 2'd1;
         else if (busy) begin
            mem_ready <= 1'b1;
            mem_rdata <= mem[mem_addr];
            for (int b = 0; b < ext_mem_pkg::strb_w; b++)
               if (mem_wstrb[b])
                  mem[mem_addr][8*b +: 8] = mem_wdata[8*b +: 8];
         end
      end
   end

endmodule

// File: tb_ext_mem.sv
module tb_ext_mem;

   localparam int num_rand_ops = 300;
   localparam int max_cycles   = num_rand_ops * 40 + 8000;  // Worst case ops plus setup

   logic clk = 1'b0;
   logic rst;
   logic invalidate;
   logic i_valid;
   logic [ext_mem_pkg::addr_w-1:0] i_addr;
   logic [ext_mem_pkg::data_w-1:0] i_rdata;
   logic i_ready;
   logic d_valid;
   logic [ext_mem_pkg::addr_w-1:0] d_addr;
   logic [ext_mem_pkg::data_w-1:0] d_wdata;
   logic [ext_mem_pkg::strb_w-1:0] d_wstrb;
   logic [ext_mem_pkg::data_w-1:0] d_rdata;
   logic d_ready;
   logic mem_valid;
   logic [ext_mem_pkg::addr_w-1:0] mem_addr;
   logic [ext_mem_pkg::data_w-1:0] mem_wdata;
   logic [ext_mem_pkg::strb_w-1:0] mem_wstrb;
   logic [ext_mem_pkg::data_w-1:0] mem_rdata;
   logic mem_ready;

   logic [ext_mem_pkg::data_w-1:0] ref_mem [1 << ext_mem_pkg::addr_w];
   logic [31:0] lfsr = 32'h6cb2;
   int d_issued = 0;
   int i_issued = 0;
   int d_ready_cnt = 0;
   int i_ready_cnt = 0;

   ext_mem u_dut (.*);
   tb_mem_model u_mem (.*);

   always #50 clk = ~clk;

   always @(posedge clk) begin
      if (d_ready)
         d_ready_cnt++;
      if (i_ready)
         i_ready_cnt++;
   end

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int k = 0; k < n; k++) begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      end
      return v;
   endfunction

   // Initial memory contents unique per address
   function automatic logic [31:0] fill_word(input logic [ext_mem_pkg::addr_w-1:0] a);
      return {2'b10, a, 2'b01, ~a};
   endfunction

   function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
      logic [31:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   task automatic check_data(input string name, input logic [ext_mem_pkg::data_w-1:0] actual,
                             input logic [ext_mem_pkg::data_w-1:0] expected);
      if (actual !== expected) begin
         $display("Fail at time %0t: %s is %h, expected %h", $time, name, actual, expected);
         $display("Test failures found");
         $fatal(1);
      end
   endtask

   task automatic check_ready_count(input string name, input int actual, input int expected);
      if (actual != expected) begin
         $display("Fail at time %0t: %s count is %0d, expected %0d", $time, name, actual,
                  expected);
         $display("Test failures found");
         $fatal(1);
      end
   endtask

   task automatic d_access(input logic [13:0] addr, input logic [31:0] wdata,
                           input logic [3:0] strb, output logic [31:0] rdata);
      @(posedge clk);
      #1;
      d_valid = 1'b1;
      d_addr  = addr;
      d_wdata = wdata;
      d_wstrb = strb;
      do begin
         @(posedge clk);
         #1;
      end while (!d_ready);
      rdata = d_rdata;
      @(posedge clk);  // Valid held through the ready cycle
      #1;
      d_valid = 1'b0;
      d_wstrb = '0;
      d_issued++;
   endtask

   task automatic i_access(input logic [13:0] addr, output logic [31:0] rdata);
      @(posedge clk);
      #1;
      i_valid = 1'b1;
      i_addr  = addr;
      do begin
         @(posedge clk);
         #1;
      end while (!i_ready);
      rdata = i_rdata;
      @(posedge clk);
      #1;
      i_valid = 1'b0;
      i_issued++;
   endtask

   task automatic d_write(input logic [13:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
      logic [31:0] unused;
      ref_mem[addr] = apply_strobe(ref_mem[addr], data, strb);
      d_access(addr, data, strb, unused);
   endtask

   task automatic d_read_check(input logic [13:0] addr, input logic [31:0] expected);
      logic [31:0] got;
      d_access(addr, '0, 4'h0, got);
      check_data("d_rdata", got, expected);
   endtask

   task automatic i_read_check(input logic [13:0] addr, input logic [31:0] expected);
      logic [31:0] got;
      i_access(addr, got);
      check_data("i_rdata", got, expected);
   endtask

   task automatic pulse_invalidate();
      @(posedge clk);
      #1;
      invalidate = 1'b1;
      @(posedge clk);
      #1;
      invalidate = 1'b0;
      // Level-two flush is held until its front end goes idle
      while (u_dut.inv_pending) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_counts();
      check_ready_count("d_ready", d_ready_cnt, d_issued);
      check_ready_count("i_ready", i_ready_cnt, i_issued);
   endtask

   // Same index, different tag forces evictions
   task automatic test_write_read();
      ext_mem_pkg::l1_addr_t a0;
      ext_mem_pkg::l1_addr_t a1;
      a0.split.tag = 9'd1;
      a0.split.index = 5'd7;
      a1.split.tag = 9'd5;
      a1.split.index = 5'd7;
      d_read_check(a0.word, ref_mem[a0.word]);
      d_write(a0.word, 32'h1234_5678, 4'hf);
      d_write(a1.word, 32'hcafe_f00d, 4'hf);
      d_read_check(a0.word, ref_mem[a0.word]);
      d_read_check(a1.word, ref_mem[a1.word]);
      d_read_check(a0.word, 32'h1234_5678);
      check_counts();
   endtask

   task automatic test_strobes();
      logic [13:0] a;
      a = 14'h0042;
      d_write(a, 32'h1111_2222, 4'hf);
      d_read_check(a, 32'h1111_2222);
      d_write(a, 32'haabb_ccdd, 4'b0101);
      d_read_check(a, 32'h11bb_22dd);
      d_write(a, 32'h9900_0000, 4'b1000);
      d_read_check(a, ref_mem[a]);
      check_counts();
   endtask

   task automatic test_backdoor();
      logic [13:0] a;
      logic [31:0] old_val;
      a = 14'h0123;
      old_val = ref_mem[a];
      d_read_check(a, old_val);
      u_mem.backdoor_write(a, 32'hdead_beef);
      ref_mem[a] = 32'hdead_beef;
      d_read_check(a, old_val);  // Still cached
      pulse_invalidate();
      d_read_check(a, 32'hdead_beef);
      i_read_check(a, 32'hdead_beef);
      check_counts();
   endtask

   // Instruction cache is not coherent with data writes
   task automatic test_stale_fetch();
      logic [13:0] a;
      logic [31:0] old_val;
      a = 14'h3e21;
      old_val = ref_mem[a];
      i_read_check(a, old_val);
      d_write(a, 32'h0bad_c0de, 4'hf);
      i_read_check(a, old_val);
      pulse_invalidate();
      i_read_check(a, 32'h0bad_c0de);
      check_counts();
   endtask

   task automatic test_same_cycle();
      fork
         d_read_check(14'h0311, ref_mem[14'h0311]);
         i_read_check(14'h2a05, ref_mem[14'h2a05]);
      join
      fork
         d_write(14'h0311, 32'h5566_7788, 4'hf);
         i_read_check(14'h2a45, ref_mem[14'h2a45]);
      join
      d_read_check(14'h0311, 32'h5566_7788);
      check_counts();
   endtask

   // Data and instruction addresses kept apart so fetches never see stale lines
   task automatic test_random();
      ext_mem_pkg::l1_addr_t da;
      ext_mem_pkg::l1_addr_t ia;
      logic [1:0]  op;
      logic [3:0]  strb;
      logic [31:0] wdata;
      for (int n = 0; n < num_rand_ops; n++) begin
         da.split.tag   = 9'(take_bits(3));
         da.split.index = 5'(take_bits(5));
         ia.split.tag   = 9'h100 | 9'(take_bits(3));
         ia.split.index = 5'(take_bits(5));
         op = 2'(take_bits(2));
         if (op == 2'd0) begin
            strb  = 4'(take_bits(4));
            wdata = take_bits(32);
            if (strb == 4'h0)
               d_read_check(da.word, ref_mem[da.word]);
            else
               d_write(da.word, wdata, strb);
         end else if (op == 2'd1)
            d_read_check(da.word, ref_mem[da.word]);
         else if (op == 2'd2)
            i_read_check(ia.word, ref_mem[ia.word]);
         else begin
            fork
               d_read_check(da.word, ref_mem[da.word]);
               i_read_check(ia.word, ref_mem[ia.word]);
            join
         end
         if (4'(take_bits(4)) == 4'h0)
            pulse_invalidate();
      end
      check_counts();
   endtask

   initial begin
      rst = 1'b1;
      invalidate = 1'b0;
      i_valid = 1'b0;
      i_addr = '0;
      d_valid = 1'b0;
      d_addr = '0;
      d_wdata = '0;
      d_wstrb = '0;
      for (int a = 0; a < (1 << ext_mem_pkg::addr_w); a++) begin
         ref_mem[a] = fill_word(14'(a));
         u_mem.backdoor_write(14'(a), fill_word(14'(a)));
      end
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b0;
      test_write_read();
      test_strobes();
      test_backdoor();
      test_stale_fetch();
      test_same_cycle();
      test_random();
      $display("All tests passed!");
      $finish;
   end

   initial begin
      repeat (max_cycles) @(posedge clk);
      $display("Watchdog timeout: the tests did not finish within %0d cycles", max_cycles);
      $display("Test failures found");
      $fatal(1);
   end

endmodule

// File: project.f
ext_mem_pkg.sv
l1_cache.sv
bus_merge.sv
l2_cache.sv
ext_mem.sv
tb_mem_model.sv
tb_ext_mem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ext_mem
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
